//--- dv/board_config_patterns.txt
// game id then feature word then regions rom rom1 wram scr0 scr1 obj col io0 io1 snd ext pri roz cchip
// id bit 8 set marks the reset row and its low byte is the game held during reset
// unlisted regions read FF00 and unknown games expect the pcr110 only feature word 1000

// FINALB
0001 1000 00FC FF00 10FF 80F0 FF00 90FF 20FF 30FF FF00 32FF FF00 FF00 FF00 FF00
// DONDOKOD
0002 6020 00F8 FF00 10FF 80F0 FF00 90FF 20FF 30FF FF00 32FF FF00 B0FF A0FE FF00
// MEGAB
0003 6003 00F8 FF00 20FF 60F1 FF00 80FF 30FF 12FF FF00 10FF FF00 40FF FF00 18FF
// THUNDFOX
0004 E004 00F8 FF00 30FF 40F0 50F0 60FF 10FE 20FF FF00 22FF FF00 80FF FF00 FF00
// GROWL
0005 6903 00F0 FF00 10FF 80F0 FF00 90FF 20FF 30FF 32FF 40FF 50FF B0FF FF00 FF00
// NINJAK
0006 68C0 00F8 FF00 10FF 80F0 FF00 90FF 20FF 30F7 FF00 40FF 60FF B0FF FF00 FF00
// PULIRULA
0007 E412 00F0 FF00 30FF 80F0 FF00 90FF 70F0 B0FF FF00 20FF 60FF A0FF 40F0 FF00
// DINOREX
0008 6203 00E0 20F0 60F0 90F0 FF00 80FF 50FF 30FF FF00 A0FF 40FF 70FF FF00 FF00
// DRIFTOUT
0009 E012 00F0 FF00 30FF 80F0 FF00 90FF 70FF B0FF FF00 20FF FF00 A0FF 40F0 FF00

// no game loaded
0000 1000 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00
// first id past the kept set
000A 1000 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00
// arbitrary unknown id
0055 1000 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00
// top of the id range
00FF 1000 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00

// reset with MEGAB applied
0103 0000 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00

//--- board_config.f
hdl/game_pkg.sv
hdl/board_map_pkg.sv
hdl/board_feature_table.sv
hdl/board_address_map.sv
hdl/game_board_config.sv
dv/game_board_config_tb.sv

//--- Bender.yml
package:
  name: board_config

sources:
  # packages first, then the tables, then the top level
  - files:
      - hdl/game_pkg.sv
      - hdl/board_map_pkg.sv
      - hdl/board_feature_table.sv
      - hdl/board_address_map.sv
      - hdl/game_board_config.sv

  - target: test
    files:
      - dv/game_board_config_tb.sv

//--- dv/game_board_config_tb.sv
module game_board_config_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam time CLK_PERIOD      = 8;  // ns
    localparam int  PATTERN_LINES   = 14; // data lines in the pattern file
    localparam int  LINE_WORDS      = 16; // id, feature word, fourteen regions
    localparam int  REGIONS         = 14;
    localparam int  WATCHDOG_CYCLES = PATTERN_LINES * 3 + 20;

    logic            clk;
    logic            rst;
    game_pkg::game_t game;

    logic        cfg_360pri_high;
    logic        cfg_360pri;
    logic        cfg_260dar;
    logic        cfg_110pcr;
    logic        cfg_190fmc;
    logic [1:0]  cfg_obj_extender;
    logic        cfg_tmp82c265;
    logic        cfg_te7750;
    logic        cfg_io_swap;
    logic        cfg_280grd;
    logic        cfg_430grw;
    logic        cfg_480scp;
    logic        cfg_100scn;
    logic        cfg_bpp15;
    logic        cfg_bppmix;
    logic [15:0] region_act [REGIONS]; // dut regions in pattern column order
    logic [15:0] feature_act;          // flags packed top bit first

    logic [15:0] pat_mem [PATTERN_LINES * LINE_WORDS];
    int          order [$]; // rows played back to back
    int          reset_row;
    integer      seed;

    string region_names [REGIONS] = '{
        "rom", "rom1", "work_ram", "screen0", "screen1", "obj", "color",
        "io0", "io1", "sound", "extension", "priority", "roz", "cchip"
    };

    game_board_config game_board_config_i (
        .clk                (clk),
        .rst                (rst),
        .game               (game),
        .cfg_360pri_high    (cfg_360pri_high),
        .cfg_360pri         (cfg_360pri),
        .cfg_260dar         (cfg_260dar),
        .cfg_110pcr         (cfg_110pcr),
        .cfg_190fmc         (cfg_190fmc),
        .cfg_obj_extender   (cfg_obj_extender),
        .cfg_tmp82c265      (cfg_tmp82c265),
        .cfg_te7750         (cfg_te7750),
        .cfg_io_swap        (cfg_io_swap),
        .cfg_280grd         (cfg_280grd),
        .cfg_430grw         (cfg_430grw),
        .cfg_480scp         (cfg_480scp),
        .cfg_100scn         (cfg_100scn),
        .cfg_bpp15          (cfg_bpp15),
        .cfg_bppmix         (cfg_bppmix),
        .cfg_addr_rom       (region_act[0]),
        .cfg_addr_rom1      (region_act[1]),
        .cfg_addr_work_ram  (region_act[2]),
        .cfg_addr_screen0   (region_act[3]),
        .cfg_addr_screen1   (region_act[4]),
        .cfg_addr_obj       (region_act[5]),
        .cfg_addr_color     (region_act[6]),
        .cfg_addr_io0       (region_act[7]),
        .cfg_addr_io1       (region_act[8]),
        .cfg_addr_sound     (region_act[9]),
        .cfg_addr_extension (region_act[10]),
        .cfg_addr_priority  (region_act[11]),
        .cfg_addr_roz       (region_act[12]),
        .cfg_addr_cchip     (region_act[13])
    );

    // same field order as the feature word, so one compare covers all flags
    assign feature_act = {cfg_360pri_high, cfg_360pri, cfg_260dar, cfg_110pcr,
                          cfg_190fmc, cfg_obj_extender, cfg_tmp82c265, cfg_te7750,
                          cfg_io_swap, cfg_280grd, cfg_430grw, cfg_480scp,
                          cfg_100scn, cfg_bpp15, cfg_bppmix};

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin // x on the dut side also fails
            $display("FAIL %s expected %04h actual %04h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "first mismatch ends the run");
        end
    endtask

    // every word of a row against the dut outputs
    task automatic check_row(input int row, input string phase);
        string name;
        int    base;
        base = row * LINE_WORDS;
        name = $sformatf("%s row %0d game %02h features", phase, row, pat_mem[base][7:0]);
        check_value(name, pat_mem[base + 1], feature_act);
        for (int k = 0; k < REGIONS; k++) begin
            name = $sformatf("%s row %0d game %02h %s", phase, row, pat_mem[base][7:0],
                             region_names[k]);
            check_value(name, pat_mem[base + 2 + k], region_act[k]);
        end
    endtask

    task automatic drive_game(input int row);
        game = game_pkg::game_t'(pat_mem[row * LINE_WORDS][7:0]); // unknown ids pass as is
    endtask

    function automatic bit is_reset_row(input int row);
        return pat_mem[row * LINE_WORDS][8]; // bit 8 flags the reset row
    endfunction

    task automatic load_patterns();
        reset_row = -1;
        $readmemh("dv/board_config_patterns.txt", pat_mem);
        for (int w = 0; w < PATTERN_LINES * LINE_WORDS; w++) begin
            if ($isunknown(pat_mem[w])) begin // missing file or short line
                $display("pattern file dv/board_config_patterns.txt is missing or incomplete");
                $display("TEST FAILED");
                $fatal(1, "no usable stimulus");
            end
        end
        for (int r = 0; r < PATTERN_LINES; r++) begin
            if (is_reset_row(r)) begin
                reset_row = r;
            end else begin
                order.push_back(r);
            end
        end
        if (reset_row < 0) begin
            $display("pattern file holds no reset row");
            $display("TEST FAILED");
            $fatal(1, "no reset expectation");
        end
    endtask

    // fisher yates over the playback order
    task automatic shuffle_order();
        int j;
        int tmp;
        for (int i = order.size() - 1; i > 0; i--) begin
            j        = $unsigned($random(seed)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
    endtask

    initial begin
        seed = 23;
        rst  = 1'b1;
        game = game_pkg::GAME_NONE;
        load_patterns();
        shuffle_order();
        drive_game(reset_row); // a real game held during reset must not leak
        repeat (2) @(posedge clk);
        #1;
        check_row(reset_row, "reset");
        rst = 1'b0;
        drive_game(order[0]);
        for (int n = 0; n < order.size(); n++) begin
            @(posedge clk);
            #1; // outputs settled, next game goes in now
            check_row(order[n], "sequence");
            if (n + 1 < order.size()) begin
                drive_game(order[n + 1]);
            end
        end
        rst = 1'b1; // reset again straight out of a mapped game
        drive_game(reset_row);
        @(posedge clk);
        #1;
        check_row(reset_row, "reset again");
        rst = 1'b0;
        $display("TEST PASSED");
        $finish;
    end

    // bound from the number of pattern lines
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d clock periods, run did not finish",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "simulation hung");
    end

endmodule

//--- hdl/game_board_config.sv
module game_board_config (
    input  logic                        clk,
    input  logic                        rst,
    input  game_pkg::game_t             game,
    output logic                        cfg_360pri_high,
    output logic                        cfg_360pri,
    output logic                        cfg_260dar,
    output logic                        cfg_110pcr,
    output logic                        cfg_190fmc,
    output logic [1:0]                  cfg_obj_extender,
    output logic                        cfg_tmp82c265,
    output logic                        cfg_te7750,
    output logic                        cfg_io_swap,
    output logic                        cfg_280grd,
    output logic                        cfg_430grw,
    output logic                        cfg_480scp,
    output logic                        cfg_100scn,
    output logic                        cfg_bpp15,
    output logic                        cfg_bppmix,
    output board_map_pkg::region_word_t cfg_addr_rom,
    output board_map_pkg::region_word_t cfg_addr_rom1,
    output board_map_pkg::region_word_t cfg_addr_work_ram,
    output board_map_pkg::region_word_t cfg_addr_screen0,
    output board_map_pkg::region_word_t cfg_addr_screen1,
    output board_map_pkg::region_word_t cfg_addr_obj,
    output board_map_pkg::region_word_t cfg_addr_color,
    output board_map_pkg::region_word_t cfg_addr_io0,
    output board_map_pkg::region_word_t cfg_addr_io1,
    output board_map_pkg::region_word_t cfg_addr_sound,
    output board_map_pkg::region_word_t cfg_addr_extension,
    output board_map_pkg::region_word_t cfg_addr_priority,
    output board_map_pkg::region_word_t cfg_addr_roz,
    output board_map_pkg::region_word_t cfg_addr_cchip
);

    // both tables see the same game and register in parallel, one cycle
    board_feature_table board_feature_table_i (
        .clk              (clk),
        .rst              (rst),
        .game             (game),
        .cfg_360pri_high  (cfg_360pri_high),
        .cfg_360pri       (cfg_360pri),
        .cfg_260dar       (cfg_260dar),
        .cfg_110pcr       (cfg_110pcr),
        .cfg_190fmc       (cfg_190fmc),
        .cfg_obj_extender (cfg_obj_extender),
        .cfg_tmp82c265    (cfg_tmp82c265),
        .cfg_te7750       (cfg_te7750),
        .cfg_io_swap      (cfg_io_swap),
        .cfg_280grd       (cfg_280grd),
        .cfg_430grw       (cfg_430grw),
        .cfg_480scp       (cfg_480scp),
        .cfg_100scn       (cfg_100scn),
        .cfg_bpp15        (cfg_bpp15),
        .cfg_bppmix       (cfg_bppmix)
    );

    board_address_map board_address_map_i (
        .clk                (clk),
        .rst                (rst),
        .game               (game),
        .cfg_addr_rom       (cfg_addr_rom),
        .cfg_addr_rom1      (cfg_addr_rom1),
        .cfg_addr_work_ram  (cfg_addr_work_ram),
        .cfg_addr_screen0   (cfg_addr_screen0),
        .cfg_addr_screen1   (cfg_addr_screen1),
        .cfg_addr_obj       (cfg_addr_obj),
        .cfg_addr_color     (cfg_addr_color),
        .cfg_addr_io0       (cfg_addr_io0),
        .cfg_addr_io1       (cfg_addr_io1),
        .cfg_addr_sound     (cfg_addr_sound),
        .cfg_addr_extension (cfg_addr_extension),
        .cfg_addr_priority  (cfg_addr_priority),
        .cfg_addr_roz       (cfg_addr_roz),
        .cfg_addr_cchip     (cfg_addr_cchip)
    );

endmodule

//--- hdl/board_address_map.sv
module board_address_map (
    input  logic                        clk,
    input  logic                        rst,
    input  game_pkg::game_t             game,
    output board_map_pkg::region_word_t cfg_addr_rom,
    output board_map_pkg::region_word_t cfg_addr_rom1,
    output board_map_pkg::region_word_t cfg_addr_work_ram,
    output board_map_pkg::region_word_t cfg_addr_screen0,
    output board_map_pkg::region_word_t cfg_addr_screen1,
    output board_map_pkg::region_word_t cfg_addr_obj,
    output board_map_pkg::region_word_t cfg_addr_color,
    output board_map_pkg::region_word_t cfg_addr_io0,
    output board_map_pkg::region_word_t cfg_addr_io1,
    output board_map_pkg::region_word_t cfg_addr_sound,
    output board_map_pkg::region_word_t cfg_addr_extension,
    output board_map_pkg::region_word_t cfg_addr_priority,
    output board_map_pkg::region_word_t cfg_addr_roz,
    output board_map_pkg::region_word_t cfg_addr_cchip
);

    // slot of each region in the map
    localparam int ROM  = 0;
    localparam int ROM1 = 1;
    localparam int WRAM = 2;
    localparam int SCR0 = 3;
    localparam int SCR1 = 4;
    localparam int OBJ  = 5;
    localparam int COL  = 6;
    localparam int IO0  = 7;
    localparam int IO1  = 8;
    localparam int SND  = 9;
    localparam int EXT  = 10;
    localparam int PRI  = 11;
    localparam int ROZ  = 12;
    localparam int CCH  = 13;

    board_map_pkg::region_word_t map_d [board_map_pkg::REGION_COUNT];
    board_map_pkg::region_word_t map_q [board_map_pkg::REGION_COUNT];

    always_comb begin
        map_d = '{default: board_map_pkg::REGION_UNMAPPED}; // unlisted regions stay off
        case (game)
            game_pkg::GAME_FINALB: begin
                map_d[ROM]  = {8'h00, 8'hFC}; // 256k program
                map_d[WRAM] = {8'h10, 8'hFF};
                map_d[COL]  = {8'h20, 8'hFF}; // tc0110pcr
                map_d[IO0]  = {8'h30, 8'hFF}; // tc0220ioc
                map_d[SND]  = {8'h32, 8'hFF}; // tc0140syt
                map_d[SCR0] = {8'h80, 8'hF0};
                map_d[OBJ]  = {8'h90, 8'hFF};
            end
            game_pkg::GAME_DONDOKOD: begin
                map_d[ROM]  = {8'h00, 8'hF8};
                map_d[WRAM] = {8'h10, 8'hFF};
                map_d[COL]  = {8'h20, 8'hFF};
                map_d[IO0]  = {8'h30, 8'hFF};
                map_d[SND]  = {8'h32, 8'hFF};
                map_d[SCR0] = {8'h80, 8'hF0};
                map_d[OBJ]  = {8'h90, 8'hFF};
                map_d[ROZ]  = {8'hA0, 8'hFE}; // tc0280grd ram
                map_d[PRI]  = {8'hB0, 8'hFF};
            end
            game_pkg::GAME_MEGAB: begin
                map_d[ROM]  = {8'h00, 8'hF8};
                map_d[SND]  = {8'h10, 8'hFF};
                map_d[IO0]  = {8'h12, 8'hFF};
                map_d[CCH]  = {8'h18, 8'hFF}; // c-chip shared ram
                map_d[WRAM] = {8'h20, 8'hFF};
                map_d[COL]  = {8'h30, 8'hFF};
                map_d[PRI]  = {8'h40, 8'hFF};
                map_d[SCR0] = {8'h60, 8'hF1}; // also decodes the even banks up to 0x6e
                map_d[OBJ]  = {8'h80, 8'hFF};
            end
            game_pkg::GAME_THUNDFOX: begin
                map_d[ROM]  = {8'h00, 8'hF8};
                map_d[COL]  = {8'h10, 8'hFE};
                map_d[IO0]  = {8'h20, 8'hFF};
                map_d[SND]  = {8'h22, 8'hFF};
                map_d[WRAM] = {8'h30, 8'hFF};
                map_d[SCR0] = {8'h40, 8'hF0}; // first tc0100scn
                map_d[SCR1] = {8'h50, 8'hF0}; // second tc0100scn
                map_d[OBJ]  = {8'h60, 8'hFF};
                map_d[PRI]  = {8'h80, 8'hFF};
            end
            game_pkg::GAME_GROWL: begin
                map_d[ROM]  = {8'h00, 8'hF0};
                map_d[WRAM] = {8'h10, 8'hFF};
                map_d[COL]  = {8'h20, 8'hFF};
                map_d[IO0]  = {8'h30, 8'hFF}; // dsw and coin
                map_d[IO1]  = {8'h32, 8'hFF}; // player inputs
                map_d[SND]  = {8'h40, 8'hFF};
                map_d[EXT]  = {8'h50, 8'hFF}; // spritebank, input3/4
                map_d[SCR0] = {8'h80, 8'hF0};
                map_d[OBJ]  = {8'h90, 8'hFF};
                map_d[PRI]  = {8'hB0, 8'hFF};
            end
            game_pkg::GAME_NINJAK: begin
                map_d[ROM]  = {8'h00, 8'hF8};
                map_d[WRAM] = {8'h10, 8'hFF};
                map_d[COL]  = {8'h20, 8'hFF};
                map_d[IO0]  = {8'h30, 8'hF7}; // te7750, watchdog at 0x38
                map_d[SND]  = {8'h40, 8'hFF};
                map_d[EXT]  = {8'h60, 8'hFF};
                map_d[SCR0] = {8'h80, 8'hF0};
                map_d[OBJ]  = {8'h90, 8'hFF};
                map_d[PRI]  = {8'hB0, 8'hFF};
            end
            game_pkg::GAME_PULIRULA: begin
                map_d[ROM]  = {8'h00, 8'hF0};
                map_d[SND]  = {8'h20, 8'hFF};
                map_d[WRAM] = {8'h30, 8'hFF};
                map_d[ROZ]  = {8'h40, 8'hF0}; // tc0430grw ram
                map_d[EXT]  = {8'h60, 8'hFF};
                map_d[COL]  = {8'h70, 8'hF0};
                map_d[SCR0] = {8'h80, 8'hF0};
                map_d[OBJ]  = {8'h90, 8'hFF};
                map_d[PRI]  = {8'hA0, 8'hFF};
                map_d[IO0]  = {8'hB0, 8'hFF}; // tc0510nio
            end
            game_pkg::GAME_DINOREX: begin
                map_d[ROM]  = {8'h00, 8'hE0}; // 2m program
                map_d[ROM1] = {8'h20, 8'hF0}; // data rom window
                map_d[IO0]  = {8'h30, 8'hFF};
                map_d[EXT]  = {8'h40, 8'hFF};
                map_d[COL]  = {8'h50, 8'hFF};
                map_d[WRAM] = {8'h60, 8'hF0};
                map_d[PRI]  = {8'h70, 8'hFF};
                map_d[OBJ]  = {8'h80, 8'hFF};
                map_d[SCR0] = {8'h90, 8'hF0};
                map_d[SND]  = {8'hA0, 8'hFF};
            end
            game_pkg::GAME_DRIFTOUT: begin
                map_d[ROM]  = {8'h00, 8'hF0};
                map_d[SND]  = {8'h20, 8'hFF};
                map_d[WRAM] = {8'h30, 8'hFF};
                map_d[ROZ]  = {8'h40, 8'hF0};
                map_d[COL]  = {8'h70, 8'hFF};
                map_d[SCR0] = {8'h80, 8'hF0};
                map_d[OBJ]  = {8'h90, 8'hFF};
                map_d[PRI]  = {8'hA0, 8'hFF};
                map_d[IO0]  = {8'hB0, 8'hFF}; // paddle shares this base
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            map_q <= '{default: board_map_pkg::REGION_UNMAPPED};
        end else begin
            map_q <= map_d;
        end
    end

    assign cfg_addr_rom       = map_q[ROM];
    assign cfg_addr_rom1      = map_q[ROM1];
    assign cfg_addr_work_ram  = map_q[WRAM];
    assign cfg_addr_screen0   = map_q[SCR0];
    assign cfg_addr_screen1   = map_q[SCR1];
    assign cfg_addr_obj       = map_q[OBJ];
    assign cfg_addr_color     = map_q[COL];
    assign cfg_addr_io0       = map_q[IO0];
    assign cfg_addr_io1       = map_q[IO1];
    assign cfg_addr_sound     = map_q[SND];
    assign cfg_addr_extension = map_q[EXT];
    assign cfg_addr_priority  = map_q[PRI];
    assign cfg_addr_roz       = map_q[ROZ];
    assign cfg_addr_cchip     = map_q[CCH];

    // cpu boots from vectors at zero, program rom must sit there
    a_rom_at_zero: assert property (@(posedge clk) disable iff (rst)
        map_q[ROM] != board_map_pkg::REGION_UNMAPPED |-> map_q[ROM][15:8] == 8'h00);

    for (genvar i = 0; i < board_map_pkg::REGION_COUNT; i++) begin : g_rst_chk
        a_unmapped_after_rst: assert property (@(posedge clk)
            rst |=> map_q[i] == board_map_pkg::REGION_UNMAPPED);
    end

endmodule

//--- hdl/board_feature_table.sv
module board_feature_table (
    input  logic                clk,
    input  logic                rst,
    input  game_pkg::game_t     game,
    output logic                cfg_360pri_high,
    output logic                cfg_360pri,
    output logic                cfg_260dar,
    output logic                cfg_110pcr,
    output logic                cfg_190fmc,
    output logic [1:0]          cfg_obj_extender,
    output logic                cfg_tmp82c265,
    output logic                cfg_te7750,
    output logic                cfg_io_swap,
    output logic                cfg_280grd,
    output logic                cfg_430grw,
    output logic                cfg_480scp,
    output logic                cfg_100scn,
    output logic                cfg_bpp15,
    output logic                cfg_bppmix
);

    board_map_pkg::feature_word_t feat_d;
    board_map_pkg::feature_word_t feat_q;

    // columns: ph pr dar pcr fmc obj tmp te io grd grw scp scn 15 mx
    always_comb begin
        case (game)
            game_pkg::GAME_FINALB:   feat_d.raw = 16'b0_0_0_1_0_00_0_0_0_0_0_0_0_0_0;
            game_pkg::GAME_DONDOKOD: feat_d.raw = 16'b0_1_1_0_0_00_0_0_0_1_0_0_0_0_0;
            game_pkg::GAME_MEGAB:    feat_d.raw = 16'b0_1_1_0_0_00_0_0_0_0_0_0_0_1_1;
            game_pkg::GAME_THUNDFOX: feat_d.raw = 16'b1_1_1_0_0_00_0_0_0_0_0_0_1_0_0;
            game_pkg::GAME_GROWL:    feat_d.raw = 16'b0_1_1_0_1_00_1_0_0_0_0_0_0_1_1;
            game_pkg::GAME_NINJAK:   feat_d.raw = 16'b0_1_1_0_1_00_0_1_1_0_0_0_0_0_0;
            game_pkg::GAME_PULIRULA: feat_d.raw = 16'b1_1_1_0_0_10_0_0_0_0_1_0_0_1_0;
            game_pkg::GAME_DINOREX:  feat_d.raw = 16'b0_1_1_0_0_01_0_0_0_0_0_0_0_1_1;
            game_pkg::GAME_DRIFTOUT: feat_d.raw = 16'b1_1_1_0_0_00_0_0_0_0_1_0_0_1_0;
            default:                 feat_d     = board_map_pkg::FEATURE_DEFAULT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            feat_q.raw <= '0; // all features off
        end else begin
            feat_q <= feat_d;
        end
    end

    assign cfg_360pri_high  = feat_q.f.pri360_high;
    assign cfg_360pri       = feat_q.f.pri360;
    assign cfg_260dar       = feat_q.f.dar260;
    assign cfg_110pcr       = feat_q.f.pcr110;
    assign cfg_190fmc       = feat_q.f.fmc190;
    assign cfg_obj_extender = feat_q.f.obj_extender;
    assign cfg_tmp82c265    = feat_q.f.tmp82c265;
    assign cfg_te7750       = feat_q.f.te7750;
    assign cfg_io_swap      = feat_q.f.io_swap;
    assign cfg_280grd       = feat_q.f.grd280;
    assign cfg_430grw       = feat_q.f.grw430;
    assign cfg_480scp       = feat_q.f.scp480;
    assign cfg_100scn       = feat_q.f.scn100;
    assign cfg_bpp15        = feat_q.f.bpp15;
    assign cfg_bppmix       = feat_q.f.bppmix;

    // mixed depth only exists on 15 bit colour boards
    a_bppmix_needs_bpp15: assert property (
        @(posedge clk) !rst |=> (!feat_q.f.bppmix || feat_q.f.bpp15));

    a_obj_extender_legal: assert property (
        @(posedge clk) disable iff (rst) feat_q.f.obj_extender != 2'd3);

endmodule

//--- hdl/board_map_pkg.sv
package board_map_pkg;

    // feature word, rows are written raw, outputs read the fields
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic       pri360_high;  // tc0360pri high priority bank
            logic       pri360;       // tc0360pri fitted
            logic       dar260;       // tc0260dar palette
            logic       pcr110;       // tc0110pcr palette
            logic       fmc190;       // tc0190fmc sprites
            logic [1:0] obj_extender; // 0 none, 1 and 2 board variants
            logic       tmp82c265;
            logic       te7750;       // te7750 io
            logic       io_swap;      // io0 and io1 swapped
            logic       grd280;       // tc0280grd roz
            logic       grw430;       // tc0430grw roz
            logic       scp480;       // tc0480scp tilemap
            logic       scn100;       // second tc0100scn
            logic       bpp15;        // 15 bit colour
            logic       bppmix;       // mixed depth, needs bpp15
        } f;
    } feature_word_t;

    // base byte is cpu a[23:16], mask byte selects compared bits
    typedef logic [15:0] region_word_t;

    localparam int REGION_COUNT = 14;

    // base ff with zero mask never decodes
    localparam region_word_t REGION_UNMAPPED = {8'hFF, 8'h00};

    // unknown board, tc0110pcr palette only
    localparam feature_word_t FEATURE_DEFAULT = 16'b0_0_0_1_0_00_0_0_0_0_0_0_0_0_0;

endpackage

//--- hdl/game_pkg.sv
package game_pkg;

    // board identifiers, 8 bit code as seen on the config bus
    typedef enum logic [7:0] {
        GAME_NONE     = 8'h00, // nothing loaded, falls to default row
        GAME_FINALB   = 8'h01,
        GAME_DONDOKOD = 8'h02,
        GAME_MEGAB    = 8'h03,
        GAME_THUNDFOX = 8'h04, // dual tc0100scn
        GAME_GROWL    = 8'h05,
        GAME_NINJAK   = 8'h06,
        GAME_PULIRULA = 8'h07,
        GAME_DINOREX  = 8'h08,
        GAME_DRIFTOUT = 8'h09
    } game_t;

endpackage
